//--- hw/i2s_pkg.sv
package i2s_pkg;

    // frame format, 96 kHz output with clk at 49.152 MHz
    localparam int sample_width      = 24;
    localparam int clks_per_bclk     = 8;    // low for the first half, high for the second
    localparam int bclks_per_channel = 32;
    localparam int bclks_per_frame   = 64;
    localparam int fifo_depth        = 4;    // in stereo frames

    localparam int phase_width = $clog2(clks_per_bclk);
    localparam int slot_width  = $clog2(bclks_per_frame);
    localparam int ptr_width   = $clog2(fifo_depth);
    localparam int count_width = $clog2(fifo_depth + 1);

    // phase counter landmarks inside one bclk period
    localparam logic [phase_width-1:0] phase_fall  = phase_width'(clks_per_bclk - 1);
    localparam logic [phase_width-1:0] phase_rise  = phase_width'(clks_per_bclk / 2 - 1);
    localparam logic [phase_width-1:0] phase_reset = phase_width'(clks_per_bclk / 2);

    // slot windows, each sample starts one bclk after its lrclk edge
    localparam logic [slot_width-1:0] slot_last   = slot_width'(bclks_per_frame - 1);
    localparam logic [slot_width-1:0] slot_right  = slot_width'(bclks_per_channel);
    localparam logic [slot_width-1:0] left_first  = slot_width'(1);
    localparam logic [slot_width-1:0] left_last   = slot_width'(sample_width);
    localparam logic [slot_width-1:0] right_first = slot_width'(bclks_per_channel + 1);
    localparam logic [slot_width-1:0] right_last  = slot_width'(bclks_per_channel + sample_width);

    localparam logic [count_width-1:0] count_full = count_width'(fifo_depth);

    typedef logic signed [sample_width-1:0] pcm_sample_t;

    typedef struct packed {
        pcm_sample_t left;
        pcm_sample_t right;
    } pcm_frame_t;  // 48 bits, left in the upper half

endpackage

//--- hw/i2s_timing_if.sv
`timescale 1ns/1ps

// bit and frame timing from the clock generator to the serializer
interface i2s_timing_if;

    logic                           bit_strobe;  // clk cycle in which bclk falls
    logic [i2s_pkg::slot_width-1:0] slot;        // bclk index in the frame, 0 to 63
    logic                           channel;     // same as lrclk, 0 = left
    logic                           frame_load;  // with the bit_strobe of slot 63
    logic                           active;      // generator out of reset

    modport gen (
        output bit_strobe,
        output slot,
        output channel,
        output frame_load,
        output active
    );

    modport ser (
        input bit_strobe,
        input slot,
        input channel,
        input frame_load,
        input active
    );

endinterface

//--- hw/pcm_frame_fifo.sv
`timescale 1ns/1ps

module pcm_frame_fifo (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                pcm_write,
    input  i2s_pkg::pcm_frame_t wr_frame,
    input  logic                pop,
    output i2s_pkg::pcm_frame_t head_frame,
    output logic                head_valid,
    output logic                fifo_full,
    output logic                overflow
);

    i2s_pkg::pcm_frame_t mem [i2s_pkg::fifo_depth];

    logic [i2s_pkg::ptr_width-1:0]   wr_ptr;
    logic [i2s_pkg::ptr_width-1:0]   rd_ptr;
    logic [i2s_pkg::count_width-1:0] count;
    logic                            push;

    assign fifo_full  = (count == i2s_pkg::count_full);
    assign head_valid = (count != '0);
    assign head_frame = mem[rd_ptr];           // oldest frame, no read latency

    // a write into a full buffer is lost
    assign push = pcm_write && !fifo_full;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_frame;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= pcm_write && fifo_full;  // one pulse per dropped frame

            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;       // depth is a power of two, wraps by itself
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // idle, or push and pop together
            endcase
        end
    end

endmodule

//--- hw/i2s_clock_gen.sv
`timescale 1ns/1ps

module i2s_clock_gen (
    input  logic      clk,
    input  logic      reset_n,
    i2s_timing_if.gen timing,
    output logic      bclk,
    output logic      lrclk
);

    logic [i2s_pkg::phase_width-1:0] phase;     // position inside one bclk period
    logic [i2s_pkg::slot_width-1:0]  slot;
    logic [i2s_pkg::slot_width-1:0]  slot_next;
    logic                            strobe_q;
    logic                            load_q;
    logic                            active_q;

    assign slot_next = slot + 1'b1;             // 63 wraps back to 0

    // phase restarts inside the high half so that the first fall comes
    // four clk after reset, with bclk held low until then
    always_ff @(posedge clk) begin
        if (reset_n) begin
            phase    <= i2s_pkg::phase_reset;
            bclk     <= 1'b0;
            strobe_q <= 1'b0;
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
            strobe_q <= 1'b0;
            if (phase == i2s_pkg::phase_fall) begin
                phase    <= '0;
                bclk     <= 1'b0;
                strobe_q <= 1'b1;               // marks the falling edge
            end else begin
                phase <= phase + 1'b1;
                if (phase == i2s_pkg::phase_rise) begin
                    bclk <= 1'b1;
                end
            end
        end
    end

    // slot count and word clock, both move only on a bclk fall
    always_ff @(posedge clk) begin
        if (reset_n) begin
            slot   <= i2s_pkg::slot_last;       // first fall opens slot 0
            lrclk  <= 1'b0;
            load_q <= 1'b0;
        end else begin
            load_q <= 1'b0;
            if (phase == i2s_pkg::phase_fall) begin
                slot   <= slot_next;
                lrclk  <= (slot_next >= i2s_pkg::slot_right);  // right half is slots 32 to 63
                load_q <= (slot_next == i2s_pkg::slot_last);
            end
        end
    end

    assign timing.bit_strobe = strobe_q;
    assign timing.slot       = slot;
    assign timing.channel    = lrclk;
    assign timing.frame_load = load_q;
    assign timing.active     = active_q;

endmodule

//--- hw/i2s_serializer.sv
`timescale 1ns/1ps

module i2s_serializer (
    input  logic                clk,
    input  logic                reset_n,
    i2s_timing_if.ser           timing,
    input  i2s_pkg::pcm_frame_t head_frame,
    input  logic                head_valid,
    output logic                pop,
    output logic                underrun,
    output logic                s_data
);

    logic [i2s_pkg::sample_width-1:0] left_sr;
    logic [i2s_pkg::sample_width-1:0] right_sr;
    logic                             in_left;
    logic                             in_right;
    logic                             load;

    // data windows, slot 0 and slot 32 carry the one bclk delay
    assign in_left  = !timing.channel
                      && (timing.slot >= i2s_pkg::left_first)
                      && (timing.slot <= i2s_pkg::left_last);
    assign in_right = timing.channel
                      && (timing.slot >= i2s_pkg::right_first)
                      && (timing.slot <= i2s_pkg::right_last);

    assign load = timing.active && timing.frame_load;
    assign pop  = load && head_valid;           // FIFO steps on the same edge that latches

    // shift registers, a missing frame loads as silence
    always_ff @(posedge clk) begin
        if (load) begin
            left_sr  <= head_valid ? head_frame.left  : '0;
            right_sr <= head_valid ? head_frame.right : '0;
        end else if (timing.bit_strobe) begin
            if (in_left) begin
                left_sr <= {left_sr[i2s_pkg::sample_width-2:0], 1'b0};
            end
            if (in_right) begin
                right_sr <= {right_sr[i2s_pkg::sample_width-2:0], 1'b0};
            end
        end
    end

    // s_data follows the bclk fall by one clk, well before the rising edge
    always_ff @(posedge clk) begin
        if (reset_n) begin
            s_data   <= 1'b0;
            underrun <= 1'b0;
        end else begin
            underrun <= load && !head_valid;
            if (timing.active && timing.bit_strobe) begin
                if (in_left) begin
                    s_data <= left_sr[i2s_pkg::sample_width-1];   // MSB first
                end else if (in_right) begin
                    s_data <= right_sr[i2s_pkg::sample_width-1];
                end else begin
                    s_data <= 1'b0;             // padding slots
                end
            end
        end
    end

endmodule

//--- hw/pcm_to_i2s_top.sv
`timescale 1ns/1ps

module pcm_to_i2s_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  i2s_pkg::pcm_sample_t pcm_left,
    input  i2s_pkg::pcm_sample_t pcm_right,
    input  logic                 pcm_write,
    output logic                 fifo_full,
    output logic                 overflow,
    output logic                 underrun,
    output logic                 bclk,
    output logic                 lrclk,
    output logic                 s_data
);

    i2s_pkg::pcm_frame_t wr_frame;
    i2s_pkg::pcm_frame_t head_frame;
    logic                head_valid;
    logic                pop;

    i2s_timing_if timing_bus ();

    // host writes one stereo pair per strobe
    assign wr_frame = '{left: pcm_left, right: pcm_right};

    pcm_frame_fifo fifo_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .pcm_write  (pcm_write),
        .wr_frame   (wr_frame),
        .pop        (pop),
        .head_frame (head_frame),
        .head_valid (head_valid),
        .fifo_full  (fifo_full),
        .overflow   (overflow)
    );

    i2s_clock_gen clock_gen_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .timing  (timing_bus.gen),
        .bclk    (bclk),
        .lrclk   (lrclk)
    );

    i2s_serializer serializer_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .timing     (timing_bus.ser),
        .head_frame (head_frame),
        .head_valid (head_valid),
        .pop        (pop),
        .underrun   (underrun),
        .s_data     (s_data)
    );

endmodule

//--- tb/pcm_to_i2s_assertions.sv
`timescale 1ns/1ps

// timing rules on the top-level I2S pins and the FIFO handshake
module pcm_to_i2s_assertions (
    input logic clk,
    input logic reset_n,
    input logic bclk,
    input logic lrclk,
    input logic pcm_write,
    input logic fifo_full,
    input logic overflow,
    input logic pop
);

    localparam int half_bclk = i2s_pkg::clks_per_bclk / 2;

    int   fail_count = 0;   // assertion failures so far
    int   hold_cnt;         // clk cycles bclk has kept its last level
    int   level;            // FIFO occupancy rebuilt from accepted writes and pops
    logic bclk_q;
    logic lrclk_q;
    logic full_q;
    logic toggled;          // bclk changed at least once since reset

    always @(posedge clk) begin
        bclk_q  <= bclk;
        lrclk_q <= lrclk;
        full_q  <= fifo_full;
        if (reset_n) begin
            hold_cnt <= 0;
            toggled  <= 1'b0;
            level    <= 0;
        end else begin
            level <= level + int'(pcm_write && !fifo_full) - int'(pop);
            if (bclk != bclk_q) begin
                hold_cnt <= 1;
                toggled  <= 1'b1;
            end else begin
                hold_cnt <= hold_cnt + 1;
            end
        end
    end

    // each bclk level lasts half a bclk period
    bclk_half_period: assert property (@(posedge clk) disable iff (reset_n)
        (toggled && bclk != bclk_q) |-> (hold_cnt == half_bclk))
        else begin
            fail_count++;
            $error("bclk level held for %0d clk cycles", hold_cnt);
        end

    lrclk_on_bclk_fall: assert property (@(posedge clk) disable iff (reset_n)
        (lrclk != lrclk_q) |-> (bclk_q && !bclk))
        else begin
            fail_count++;
            $error("lrclk changed outside a bclk falling edge");
        end

    // overflow answers a write that met a full FIFO one clk earlier
    overflow_needs_full: assert property (@(posedge clk) disable iff (reset_n)
        overflow |-> full_q)
        else begin
            fail_count++;
            $error("overflow pulsed while the FIFO was not full");
        end

    pop_needs_data: assert property (@(posedge clk) disable iff (reset_n)
        pop |-> (level > 0))
        else begin
            fail_count++;
            $error("pop issued on an empty FIFO");
        end

endmodule

bind pcm_to_i2s_top pcm_to_i2s_assertions assertions_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .bclk       (bclk),
    .lrclk      (lrclk),
    .pcm_write  (pcm_write),
    .fifo_full  (fifo_full),
    .overflow   (overflow),
    .pop        (pop)
);

//--- tb/pcm_to_i2s_tb.sv
`timescale 1ns/1ps

module pcm_to_i2s_tb;

    localparam int frame_slots     = i2s_pkg::bclks_per_frame;
    localparam int clks_per_frame  = i2s_pkg::clks_per_bclk * i2s_pkg::bclks_per_frame;
    localparam int reset_cycles    = 8;
    localparam int n_data          = 12;   // paced random frames
    localparam int n_idle          = 8;    // frame periods without writes
    localparam int n_burst         = 8;    // back to back writes
    localparam int n_tail          = 4;    // paced writes after the burst
    localparam int frames_tested   = n_data + n_idle + n_burst + n_tail;
    localparam int watchdog_cycles = (frames_tested + 4) * clks_per_frame;

    logic                 clk = 1'b0;
    logic                 reset_n;
    i2s_pkg::pcm_sample_t pcm_left;
    i2s_pkg::pcm_sample_t pcm_right;
    logic                 pcm_write;
    logic                 fifo_full;
    logic                 overflow;
    logic                 underrun;
    logic                 bclk;
    logic                 lrclk;
    logic                 s_data;

    logic [31:0] rng_state       = 32'h9f81;
    int          mismatch_count  = 0;
    int          other_count     = 0;
    int          frames_compared = 0;
    int          expected_pushes = 0;
    int          underrun_count  = 0;
    int          overflow_count  = 0;
    int          full_cycles     = 0;

    i2s_pkg::pcm_frame_t    expected_q [$];   // frames in the order they must come out
    logic [frame_slots-1:0] decoded_q  [$];   // slot bits rebuilt from the I2S pins

    // monitor state
    int                  since_reset   = 0;
    int                  last_underrun = -1;
    int                  clk_count     = 0;
    int                  bclk_rises    = 0;
    logic                bclk_q        = 1'b0;
    logic                pending_valid = 1'b0;
    logic                ovf_due       = 1'b0;
    i2s_pkg::pcm_frame_t pending_frame;

    // decoder state
    int                     slot_idx  = -1;   // first bclk rise after reset is slot 0
    logic                   lr_prev   = 1'b0;
    logic                   capturing = 1'b0;
    logic [frame_slots-1:0] frame_bits;

    logic [frame_slots-1:0] got_bits;
    i2s_pkg::pcm_frame_t    exp_frame;

    pcm_to_i2s_top pcm_to_i2s_top_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .pcm_left  (pcm_left),
        .pcm_right (pcm_right),
        .pcm_write (pcm_write),
        .fifo_full (fifo_full),
        .overflow  (overflow),
        .underrun  (underrun),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .s_data    (s_data)
    );

    always #2 clk = ~clk;   // 4 ns period

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        if (got !== expected) begin
            mismatch_count++;
            $display("ERR %0t: %s, got %h expected %h", $time, what, got, expected);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic draw_sample(output i2s_pkg::pcm_sample_t s);
        rng_state = xorshift32(rng_state);
        s = rng_state[i2s_pkg::sample_width-1:0];
    endtask

    // slot s of a frame sits at bit frame_slots-1-s
    // left MSB in slot 1, right MSB in slot 33, all other slots zero
    function automatic logic [frame_slots-1:0] i2s_slot_bits(input i2s_pkg::pcm_frame_t f);
        logic [frame_slots-1:0] bits;
        bits = '0;
        for (int i = 0; i < i2s_pkg::sample_width; i++) begin
            bits[frame_slots - 2 - i] = f.left[i2s_pkg::sample_width - 1 - i];
            bits[frame_slots - 2 - i2s_pkg::bclks_per_channel - i] =
                f.right[i2s_pkg::sample_width - 1 - i];
        end
        return bits;
    endfunction

    // one paced write that waits for room first
    task automatic write_frame(input i2s_pkg::pcm_sample_t l, input i2s_pkg::pcm_sample_t r);
        @(negedge clk);
        while (fifo_full) @(negedge clk);
        @(posedge clk);
        pcm_left  <= l;
        pcm_right <= r;
        pcm_write <= 1'b1;
        @(posedge clk);
        pcm_write <= 1'b0;
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatch, %0d other, %0d assertion, %0d frames compared",
                 mismatch_count, other_count,
                 pcm_to_i2s_top_inst.assertions_inst.fail_count, frames_compared);
    endtask

    // reset values, clock ratios, overflow rule and the expected frame queue
    always @(negedge clk) begin
        if (reset_n) begin
            check_value(64'({bclk, lrclk, s_data, fifo_full, overflow, underrun}), '0,
                        "outputs during reset");
            since_reset   = 0;
            pending_valid = 1'b0;
            ovf_due       = 1'b0;
        end else begin
            since_reset++;
            if (since_reset <= 4) begin
                check_value(64'({bclk, lrclk, s_data, fifo_full, overflow, underrun}), '0,
                            "outputs right after reset");
            end
            // an empty load goes ahead of a write the FIFO has not taken yet
            if (underrun) begin
                if (last_underrun >= 0) begin
                    check_value(64'((since_reset - last_underrun) % clks_per_frame), 64'd0,
                                "spacing of underrun pulses");
                end
                last_underrun = since_reset;
                underrun_count++;
                expected_q.push_back('0);
                expected_pushes++;
            end
            if (pending_valid) begin
                expected_q.push_back(pending_frame);
                expected_pushes++;
            end
            pending_valid = pcm_write && !fifo_full;
            pending_frame = '{left: pcm_left, right: pcm_right};
            check_value(64'(overflow), 64'(ovf_due), "overflow after a write into a full FIFO");
            ovf_due = pcm_write && fifo_full;
            if (overflow) overflow_count++;
            if (fifo_full) full_cycles++;
            clk_count++;
            if (bclk && !bclk_q) begin
                if (bclk_rises > 0) begin
                    check_value(64'(clk_count), 64'(i2s_pkg::clks_per_bclk), "bclk period");
                end
                clk_count = 0;
                bclk_rises++;
            end else if (!bclk && bclk_q && bclk_rises > 0) begin
                check_value(64'(clk_count), 64'(i2s_pkg::clks_per_bclk / 2), "bclk high time");
            end
            bclk_q = bclk;
        end
    end

    // I2S decoder where frames start at the lrclk falling edge
    always @(posedge bclk) begin
        slot_idx++;
        if (lr_prev && !lrclk) begin
            check_value(64'(slot_idx), 64'(frame_slots), "bclk periods per lrclk period");
            slot_idx  = 0;
            capturing = 1'b1;
        end else if (!lr_prev && lrclk) begin
            check_value(64'(slot_idx), 64'(i2s_pkg::bclks_per_channel), "lrclk low time");
        end
        lr_prev = lrclk;
        if (capturing && slot_idx < frame_slots) begin
            frame_bits[frame_slots - 1 - slot_idx] = s_data;
            if (slot_idx == frame_slots - 1) decoded_q.push_back(frame_bits);
        end
    end

    always @(posedge clk) begin
        if (decoded_q.size() != 0) begin
            got_bits = decoded_q.pop_front();
            if (expected_q.size() == 0) begin
                other_count++;
                $display("decoded frame %0d at %0t has no written or underrun frame behind it",
                         frames_compared, $time);
            end else begin
                exp_frame = expected_q.pop_front();
                check_value(64'(got_bits), 64'(i2s_slot_bits(exp_frame)),
                            $sformatf("slot bits of frame %0d", frames_compared));
            end
            frames_compared++;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d clk cycles", watchdog_cycles);
        report_counts();
        $display("sim failed");
        $finish;
    end

    initial begin
        i2s_pkg::pcm_sample_t left;
        i2s_pkg::pcm_sample_t right;
        int                   mark;
        int                   target;

        reset_n   = 1'b1;   // active high
        pcm_write = 1'b0;
        pcm_left  = '0;
        pcm_right = '0;
        repeat (reset_cycles) @(posedge clk);
        reset_n <= 1'b0;

        for (int i = 0; i < n_data; i++) begin
            draw_sample(left);
            draw_sample(right);
            write_frame(left, right);
        end

        // writes stop so the FIFO drains and then runs dry
        mark = underrun_count;
        repeat (n_idle * clks_per_frame) @(posedge clk);
        if (underrun_count - mark < n_idle - i2s_pkg::fifo_depth - 1) begin
            other_count++;
            $display("only %0d underrun pulses in %0d idle frames", underrun_count - mark, n_idle);
        end

        // one write per clk fills the FIFO and the rest are dropped
        mark   = overflow_count;
        target = full_cycles;
        @(posedge clk);
        for (int i = 0; i < n_burst; i++) begin
            draw_sample(left);
            draw_sample(right);
            pcm_left  <= left;
            pcm_right <= right;
            pcm_write <= 1'b1;
            @(posedge clk);
        end
        pcm_write <= 1'b0;
        repeat (3) @(posedge clk);
        if (full_cycles == target) begin
            other_count++;
            $display("fifo_full never went high during the write burst");
        end
        if (overflow_count - mark < n_burst - i2s_pkg::fifo_depth - 1) begin
            other_count++;
            $display("only %0d overflow pulses for the write burst", overflow_count - mark);
        end

        for (int i = 0; i < n_tail; i++) begin
            draw_sample(left);
            draw_sample(right);
            write_frame(left, right);
        end

        // let the last write reach the queue, then drain everything written
        repeat (4) @(posedge clk);
        target = expected_pushes;
        while (frames_compared < target) @(posedge clk);

        report_counts();
        if (mismatch_count == 0 && other_count == 0
            && pcm_to_i2s_top_inst.assertions_inst.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- pcm_to_i2s_top.f
hw/i2s_pkg.sv
hw/i2s_timing_if.sv
hw/pcm_frame_fifo.sv
hw/i2s_clock_gen.sv
hw/i2s_serializer.sv
hw/pcm_to_i2s_top.sv
tb/pcm_to_i2s_assertions.sv
tb/pcm_to_i2s_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pcm_to_i2s_tb -f pcm_to_i2s_top.f -o pcm_to_i2s_sim \
    && ./obj_dir/pcm_to_i2s_sim +verilator+error+limit+1000 > "$log" 2>&1 \
    || echo "build or simulation returned an error"

cat "$log" 2>/dev/null

grep -qx "sim passed" "$log" && echo "result: pass" && exit 0 \
    || { echo "result: fail"; exit 1; }
